/* vgaPkg.sv */
package vgaPkg;

	localparam int countWidth = 10; // Width of both pixel counters

	// Horizontal timing in pixels
	localparam logic [countWidth-1:0] hActive = 10'd640;
	localparam logic [countWidth-1:0] hFront = 10'd16;
	localparam logic [countWidth-1:0] hSync = 10'd96;
	localparam logic [countWidth-1:0] hBack = 10'd48;

	// Vertical timing in lines
	localparam logic [countWidth-1:0] vActive = 10'd480;
	localparam logic [countWidth-1:0] vFront = 10'd10;
	localparam logic [countWidth-1:0] vSync = 10'd2;
	localparam logic [countWidth-1:0] vBack = 10'd33;

	// Windows of the active low sync pulses
	localparam logic [countWidth-1:0] hSyncStart = hActive + hFront;
	localparam logic [countWidth-1:0] hSyncEnd = hSyncStart + hSync;
	localparam logic [countWidth-1:0] vSyncStart = vActive + vFront;
	localparam logic [countWidth-1:0] vSyncEnd = vSyncStart + vSync;

	localparam logic [countWidth-1:0] hTotal = hSyncEnd + hBack; // 800
	localparam logic [countWidth-1:0] vTotal = vSyncEnd + vBack; // 525

endpackage

/* boardPkg.sv */
package boardPkg;

	typedef enum logic [1:0] {
		cellHidden = 2'd0,
		cellOpen = 2'd1,
		cellFlag = 2'd2,
		cellMine = 2'd3
	} cellCode;

	typedef enum logic [1:0] {
		gameIdle = 2'd0,
		gamePlaying = 2'd1,
		gameWon = 2'd2,
		gameLost = 2'd3
	} gameState;

	// Opcodes written to the command register
	typedef enum logic [1:0] {
		cmdIdle = 2'd0,
		cmdStart = 2'd1,
		cmdWin = 2'd2,
		cmdLose = 2'd3
	} gameCmd;

	// APB register map
	localparam logic [11:0] addrCmd = 12'h000;
	localparam logic [11:0] addrStatus = 12'h004;
	localparam logic [11:0] addrCellBase = 12'h100; // Cell i at base + 4*i

	// Pixel colours as 24-bit RGB
	localparam logic [23:0] colHidden = 24'h404040;
	localparam logic [23:0] colOpen = 24'hC0C0C0;
	localparam logic [23:0] colFlag = 24'hFFFF00;
	localparam logic [23:0] colMine = 24'hFF00FF;
	localparam logic [23:0] colLine = 24'hFFFFFF;
	localparam logic [23:0] colLineWon = 24'h00FF00;
	localparam logic [23:0] colLineLost = 24'hFF0000;
	localparam logic [23:0] colBlank = 24'h000000;

endpackage

/* vgaTiming.sv */
module vgaTiming (
	input  logic clk,
	input  logic rstN,
	output logic [vgaPkg::countWidth-1:0] hCount,
	output logic [vgaPkg::countWidth-1:0] vCount,
	output logic hSyncRaw,
	output logic vSyncRaw,
	output logic active
);

	logic hWrap;
	logic vWrap;

	assign hWrap = hCount == vgaPkg::hTotal - 1;
	assign vWrap = vCount == vgaPkg::vTotal - 1;

	// Free running raster counters
	always_ff @(posedge clk) begin
		if (!rstN) begin
			hCount <= '0;
			vCount <= '0;
		end else begin
			if (hWrap) begin
				hCount <= '0;
			end else begin
				hCount <= hCount + 1'b1;
			end

			if (hWrap) begin // One line done
				if (vWrap) begin
					vCount <= '0;
				end else begin
					vCount <= vCount + 1'b1;
				end
			end
		end
	end

	assign hSyncRaw = !(hCount >= vgaPkg::hSyncStart && hCount < vgaPkg::hSyncEnd);
	assign vSyncRaw = !(vCount >= vgaPkg::vSyncStart && vCount < vgaPkg::vSyncEnd);
	assign active = (hCount < vgaPkg::hActive) && (vCount < vgaPkg::vActive);

	hCountInRange: assert property (
		@(posedge clk) disable iff (!rstN)
		hCount < vgaPkg::hTotal
	);

endmodule

/* gameControl.sv */
module gameControl #(
	parameter int cellCount = 50
) (
	input  logic clk,
	input  logic rstN,
	input  logic [11:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output boardPkg::gameState state,
	output logic cellWe,
	output logic [$clog2(cellCount)-1:0] cellAddr,
	output boardPkg::cellCode cellWdata,
	output logic boardClear,
	input  boardPkg::cellCode apbRdata
);

	localparam int addrW = $clog2(cellCount);

	logic access;
	logic wrAccess;
	logic isCmd;
	logic isStatus;
	logic isCell;
	logic [11:0] cellOff;
	logic cmdErr;
	logic cellErr;
	boardPkg::gameCmd cmd;
	boardPkg::gameState stateNext;

	assign access = psel && penable; // APB access phase
	assign wrAccess = access && pwrite;

	assign isCmd = paddr == boardPkg::addrCmd;
	assign isStatus = paddr == boardPkg::addrStatus;
	assign cellOff = paddr - boardPkg::addrCellBase;
	assign isCell = (paddr >= boardPkg::addrCellBase) && (cellOff[1:0] == 2'b00)
		&& (cellOff[11:2] < cellCount);

	assign cmd = boardPkg::gameCmd'(pwdata[1:0]);

	// Game FSM driven only by command writes
	always_comb begin
		stateNext = state;
		cmdErr = 1'b0;
		if (wrAccess && isCmd) begin
			unique case (cmd)
				boardPkg::cmdIdle: stateNext = boardPkg::gameIdle;
				boardPkg::cmdStart: stateNext = boardPkg::gamePlaying;
				boardPkg::cmdWin: begin
					if (state == boardPkg::gamePlaying) begin
						stateNext = boardPkg::gameWon;
					end else begin
						cmdErr = 1'b1; // Only a running game can end
					end
				end
				boardPkg::cmdLose: begin
					if (state == boardPkg::gamePlaying) begin
						stateNext = boardPkg::gameLost;
					end else begin
						cmdErr = 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= boardPkg::gameIdle;
		end else begin
			state <= stateNext;
		end
	end

	assign boardClear = wrAccess && isCmd && (cmd == boardPkg::cmdStart);
	assign cellErr = pwrite && isCell && (state != boardPkg::gamePlaying);
	assign cellWe = wrAccess && isCell && (state == boardPkg::gamePlaying);
	assign cellAddr = cellOff[addrW+1:2];
	assign cellWdata = boardPkg::cellCode'(pwdata[1:0]);

	// Status is read only
	assign pslverr = access && (!(isCmd || isStatus || isCell) || cmdErr || cellErr
		|| (pwrite && isStatus));
	assign pready = 1'b1;

	always_comb begin
		prdata = '0;
		if (isStatus) begin
			prdata[1:0] = state;
		end else if (isCell) begin
			prdata[1:0] = apbRdata;
		end
	end

	cellWeOnlyPlaying: assert property (
		@(posedge clk) disable iff (!rstN)
		cellWe |-> state == boardPkg::gamePlaying
	);

	noWriteDuringClear: assert property (
		@(posedge clk) disable iff (!rstN)
		!(cellWe && boardClear)
	);

endmodule

/* cellMemory.sv */
module cellMemory #(
	parameter int cellCount = 50
) (
	input  logic clk,
	input  logic rstN,
	input  logic we,
	input  logic [$clog2(cellCount)-1:0] wAddr,
	input  boardPkg::cellCode wData,
	input  logic clear,
	input  logic [$clog2(cellCount)-1:0] apbAddr,
	input  logic [$clog2(cellCount)-1:0] renderAddr,
	output boardPkg::cellCode apbData,
	output boardPkg::cellCode renderData
);

	boardPkg::cellCode cells [cellCount];

	// Board clears as a whole on reset or game start
	always_ff @(posedge clk) begin
		if (!rstN || clear) begin
			for (int i = 0; i < cellCount; i++) begin
				cells[i] <= boardPkg::cellHidden;
			end
		end else if (we) begin
			cells[wAddr] <= wData;
		end
	end

	// Two asynchronous read ports
	always_comb begin
		if (apbAddr < cellCount) begin
			apbData = cells[apbAddr];
		end else begin
			apbData = boardPkg::cellHidden; // Unmapped index
		end
	end

	always_comb begin
		if (renderAddr < cellCount) begin
			renderData = cells[renderAddr];
		end else begin
			renderData = boardPkg::cellHidden;
		end
	end

	wAddrInRange: assert property (
		@(posedge clk) disable iff (!rstN)
		we |-> wAddr < cellCount
	);

endmodule

/* boardRenderer.sv */
module boardRenderer #(
	parameter int cols = 10,
	parameter int rows = 5,
	parameter int cellW = 64,
	parameter int cellH = 96
) (
	input  logic clk,
	input  logic rstN,
	input  logic [vgaPkg::countWidth-1:0] hCount,
	input  logic [vgaPkg::countWidth-1:0] vCount,
	input  logic hSyncRaw,
	input  logic vSyncRaw,
	input  logic active,
	input  boardPkg::gameState state,
	output logic [$clog2(cols*rows)-1:0] renderAddr,
	input  boardPkg::cellCode renderData,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b,
	output logic hsync,
	output logic vsync,
	output logic de
);

	localparam int colW = $clog2(cols);
	localparam int rowW = $clog2(rows);
	localparam int addrW = $clog2(cols*rows);

	logic [colW-1:0] colS1;
	logic [rowW-1:0] rowS1;
	logic lineS1;
	logic hSyncS1;
	logic vSyncS1;
	logic activeS1;
	logic [23:0] pixel;

	// Stage 1 finds the grid position of the pixel
	always_ff @(posedge clk) begin
		colS1 <= colW'(hCount / cellW);
		rowS1 <= rowW'(vCount / cellH);
		lineS1 <= ((hCount % cellW) < 2) || ((vCount % cellH) < 2); // 2 px border
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			hSyncS1 <= 1'b1;
			vSyncS1 <= 1'b1;
			activeS1 <= 1'b0;
		end else begin
			hSyncS1 <= hSyncRaw;
			vSyncS1 <= vSyncRaw;
			activeS1 <= active;
		end
	end

	// Blanking positions fall outside the board
	assign renderAddr = activeS1 ? addrW'(rowS1 * cols + colS1) : '0;

	always_comb begin
		if (!activeS1) begin
			pixel = boardPkg::colBlank;
		end else if (lineS1) begin
			case (state) // Grid lines show the result
				boardPkg::gameWon: pixel = boardPkg::colLineWon;
				boardPkg::gameLost: pixel = boardPkg::colLineLost;
				default: pixel = boardPkg::colLine;
			endcase
		end else begin
			case (renderData)
				boardPkg::cellOpen: pixel = boardPkg::colOpen;
				boardPkg::cellFlag: pixel = boardPkg::colFlag;
				boardPkg::cellMine: pixel = boardPkg::colMine;
				default: pixel = boardPkg::colHidden;
			endcase
		end
	end

	// Stage 2 registers the colour with aligned syncs
	always_ff @(posedge clk) begin
		if (!rstN) begin
			{r, g, b} <= boardPkg::colBlank;
			hsync <= 1'b1;
			vsync <= 1'b1;
			de <= 1'b0;
		end else begin
			{r, g, b} <= pixel;
			hsync <= hSyncS1;
			vsync <= vSyncS1;
			de <= activeS1;
		end
	end

	renderAddrOnBoard: assert property (
		@(posedge clk) disable iff (!rstN)
		activeS1 |-> renderAddr < cols * rows
	);

endmodule

/* boardDisplay.sv */
module boardDisplay #(
	parameter int cols = 10,
	parameter int rows = 5,
	parameter int cellW = 64,
	parameter int cellH = 96
) (
	input  logic clk,
	input  logic rstN,
	input  logic [11:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b,
	output logic hsync,
	output logic vsync,
	output logic de
);

	localparam int cellCount = cols * rows;
	localparam int addrW = $clog2(cellCount);

	logic [vgaPkg::countWidth-1:0] hCount;
	logic [vgaPkg::countWidth-1:0] vCount;
	logic hSyncRaw;
	logic vSyncRaw;
	logic active;
	boardPkg::gameState state;
	logic cellWe;
	logic [addrW-1:0] cellAddr;
	boardPkg::cellCode cellWdata;
	logic boardClear;
	boardPkg::cellCode apbRdata;
	logic [addrW-1:0] renderAddr;
	boardPkg::cellCode renderData;

	vgaTiming vgaTiming_i (
		.clk(clk), .rstN(rstN), .hCount(hCount), .vCount(vCount),
		.hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw), .active(active)
	);

	gameControl #(.cellCount(cellCount)) gameControl_i (
		.clk(clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .state(state), .cellWe(cellWe), .cellAddr(cellAddr),
		.cellWdata(cellWdata), .boardClear(boardClear), .apbRdata(apbRdata)
	);

	// APB reads and writes share one cell index
	cellMemory #(.cellCount(cellCount)) cellMemory_i (
		.clk(clk), .rstN(rstN), .we(cellWe), .wAddr(cellAddr), .wData(cellWdata),
		.clear(boardClear), .apbAddr(cellAddr), .renderAddr(renderAddr),
		.apbData(apbRdata), .renderData(renderData)
	);

	boardRenderer #(
		.cols(cols), .rows(rows), .cellW(cellW), .cellH(cellH)
	) boardRenderer_i (
		.clk(clk), .rstN(rstN), .hCount(hCount), .vCount(vCount),
		.hSyncRaw(hSyncRaw), .vSyncRaw(vSyncRaw), .active(active), .state(state),
		.renderAddr(renderAddr), .renderData(renderData),
		.r(r), .g(g), .b(b), .hsync(hsync), .vsync(vsync), .de(de)
	);

endmodule

/* tbBoardDisplay.sv */
module tbBoardDisplay;

	localparam int cols = 10;
	localparam int rows = 5;
	localparam int cellW = 64;
	localparam int cellH = 96;
	localparam int cellCount = cols * rows;
	localparam int frameCycles = 800 * 525;

	logic clk;
	logic rstN;
	logic [11:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	logic hsync;
	logic vsync;
	logic de;
	logic [23:0] rgb;

	boardPkg::cellCode shadowCells [cellCount];
	boardPkg::gameState shadowState;
	logic expErr;
	logic [31:0] expRdata;
	logic scanOn; // Pixel checks only over whole frames with a quiet bus
	logic deLast;
	int pixX;
	int pixY;
	int hLow;
	int vLow;
	int seed = 32'hce20;
	int apbErrors = 0;
	int pixelErrors = 0;
	int syncErrors = 0;
	int timeouts = 0;

	boardDisplay boardDisplay_i (
		.clk(clk), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .r(r), .g(g), .b(b), .hsync(hsync), .vsync(vsync), .de(de)
	);

	assign rgb = {r, g, b};

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Screen position of the pixel currently on the outputs
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pixX <= 0;
			pixY <= 0;
			hLow <= 0;
			vLow <= 0;
			deLast <= 1'b0;
		end else begin
			if (!vsync) begin
				pixX <= 0;
				pixY <= 0;
			end else if (de) begin
				pixX <= pixX + 1;
			end else if (deLast) begin // End of a visible line
				pixX <= 0;
				pixY <= pixY + 1;
			end
			hLow <= hsync ? 0 : hLow + 1;
			vLow <= vsync ? 0 : vLow + 1;
			deLast <= de;
		end
	end

	function automatic logic [23:0] pixelColour(input int x, input int y);
		if ((x % cellW) < 2 || (y % cellH) < 2) begin
			case (shadowState)
				boardPkg::gameWon: return boardPkg::colLineWon;
				boardPkg::gameLost: return boardPkg::colLineLost;
				default: return boardPkg::colLine;
			endcase
		end
		case (shadowCells[(y / cellH) * cols + x / cellW])
			boardPkg::cellOpen: return boardPkg::colOpen;
			boardPkg::cellFlag: return boardPkg::colFlag;
			boardPkg::cellMine: return boardPkg::colMine;
			default: return boardPkg::colHidden;
		endcase
	endfunction

	function automatic int cellIndex(input logic [11:0] addr);
		int off;
		off = int'(addr) - int'(boardPkg::addrCellBase);
		if (off < 0 || off % 4 != 0 || off / 4 >= cellCount) begin
			return -1;
		end
		return off / 4;
	endfunction

	function automatic logic [11:0] addrOf(input int i);
		return boardPkg::addrCellBase + 12'(4 * i);
	endfunction

	task automatic finishRun();
		$display("errors: apb=%0d pixel=%0d sync=%0d timeout=%0d",
			apbErrors, pixelErrors, syncErrors, timeouts);
		if (apbErrors + pixelErrors + syncErrors + timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	// One APB transfer checked against the shadow model
	task automatic busAccess(input logic write, input logic [11:0] addr, input logic [31:0] data);
		int idx;
		int n;
		boardPkg::gameState nextState;
		logic clearBoard;
		idx = cellIndex(addr);
		nextState = shadowState;
		clearBoard = 1'b0;
		expErr = 1'b0;
		expRdata = '0;
		if (addr == boardPkg::addrCmd) begin
			if (write) begin
				case (data[1:0])
					boardPkg::cmdIdle: nextState = boardPkg::gameIdle;
					boardPkg::cmdStart: begin
						nextState = boardPkg::gamePlaying;
						clearBoard = 1'b1;
					end
					boardPkg::cmdWin: begin
						expErr = shadowState != boardPkg::gamePlaying;
						nextState = expErr ? shadowState : boardPkg::gameWon;
					end
					default: begin
						expErr = shadowState != boardPkg::gamePlaying;
						nextState = expErr ? shadowState : boardPkg::gameLost;
					end
				endcase
			end
		end else if (addr == boardPkg::addrStatus) begin
			expErr = write; // Read only
			expRdata[1:0] = shadowState;
		end else if (idx >= 0) begin
			expRdata[1:0] = shadowCells[idx];
			expErr = write && shadowState != boardPkg::gamePlaying;
		end else begin
			expErr = 1'b1;
		end

		@(posedge clk);
		#1;
		paddr = addr;
		pwrite = write;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!pready && n < 16);
		if (!pready) begin
			$display("APB access to address %h never completed", addr);
			timeouts++;
			finishRun();
		end
		#1;
		psel = 1'b0;
		penable = 1'b0;

		if (clearBoard) begin
			foreach (shadowCells[i]) shadowCells[i] = boardPkg::cellHidden;
		end
		if (write && idx >= 0 && !expErr) begin
			shadowCells[idx] = boardPkg::cellCode'(data[1:0]);
		end
		shadowState = nextState;
	endtask

	task automatic writeReg(input logic [11:0] addr, input logic [31:0] data);
		busAccess(1'b1, addr, data);
	endtask

	task automatic readReg(input logic [11:0] addr);
		busAccess(1'b0, addr, 32'h0);
	endtask

	task automatic checkAllCells();
		for (int i = 0; i < cellCount; i++) begin
			readReg(addrOf(i));
		end
	endtask

	task automatic fillRandom();
		logic [31:0] code;
		for (int i = 0; i < cellCount; i++) begin
			code = $random(seed);
			writeReg(addrOf(i), {30'd0, code[1:0]});
		end
	endtask

	task automatic waitVsync(input logic level);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (vsync !== level && n < frameCycles);
		if (vsync !== level) begin
			$display("Timed out waiting for vsync to reach %0d", level);
			timeouts++;
			finishRun();
		end
	endtask

	// Checks run from one vsync pulse to the next
	task automatic scanFrame();
		waitVsync(1'b1);
		waitVsync(1'b0);
		@(posedge clk);
		#1 scanOn = 1'b1;
		waitVsync(1'b1);
		waitVsync(1'b0);
		@(posedge clk);
		#1 scanOn = 1'b0;
	endtask

	resetOutputs: assert property (@(posedge clk) $rose(rstN) |-> hsync && vsync && !de && rgb == 0)
		else begin
			syncErrors++;
			$display("FAIL after reset hsync=%h vsync=%h de=%h rgb=%h",
				$sampled(hsync), $sampled(vsync), $sampled(de), $sampled(rgb));
		end

	pixelMatch: assert property (@(posedge clk) disable iff (!rstN)
		scanOn && de |-> rgb == pixelColour(pixX, pixY))
		else begin
			pixelErrors++;
			$display("FAIL rgb at x=%0d y=%0d exp %h got %h", $sampled(pixX), $sampled(pixY),
				pixelColour($sampled(pixX), $sampled(pixY)), $sampled(rgb));
		end

	blankOutside: assert property (@(posedge clk) disable iff (!rstN) !de |-> rgb == 0)
		else begin
			pixelErrors++;
			$display("FAIL rgb exp 000000 got %h while de is low", $sampled(rgb));
		end

	lineLength: assert property (@(posedge clk) disable iff (!rstN)
		scanOn && $fell(de) |-> pixX == 640)
		else begin
			syncErrors++;
			$display("FAIL de run length exp %h got %h", 640, $sampled(pixX));
		end

	frameLines: assert property (@(posedge clk) disable iff (!rstN)
		scanOn && $fell(vsync) |-> pixY == 480)
		else begin
			syncErrors++;
			$display("FAIL lines per frame exp %h got %h", 480, $sampled(pixY));
		end

	hsyncWidth: assert property (@(posedge clk) disable iff (!rstN) $rose(hsync) |-> hLow == 96)
		else begin
			syncErrors++;
			$display("FAIL hsync low cycles exp %h got %h", 96, $sampled(hLow));
		end

	vsyncWidth: assert property (@(posedge clk) disable iff (!rstN) $rose(vsync) |-> vLow == 1600)
		else begin
			syncErrors++;
			$display("FAIL vsync low cycles exp %h got %h", 1600, $sampled(vLow));
		end

	readyHigh: assert property (@(posedge clk) disable iff (!rstN) psel && penable |-> pready)
		else begin
			apbErrors++;
			$display("FAIL pready exp 1 got %h", $sampled(pready));
		end

	slaveError: assert property (@(posedge clk) disable iff (!rstN)
		psel && penable |-> pslverr == expErr)
		else begin
			apbErrors++;
			$display("FAIL pslverr at %h exp %h got %h", $sampled(paddr), $sampled(expErr),
				$sampled(pslverr));
		end

	readData: assert property (@(posedge clk) disable iff (!rstN)
		psel && penable && !pwrite |-> prdata == expRdata)
		else begin
			apbErrors++;
			$display("FAIL prdata at %h exp %h got %h", $sampled(paddr), $sampled(expRdata),
				$sampled(prdata));
		end

	initial begin
		rstN = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		scanOn = 1'b0;
		expErr = 1'b0;
		expRdata = '0;
		shadowState = boardPkg::gameIdle;
		foreach (shadowCells[i]) shadowCells[i] = boardPkg::cellHidden;
		repeat (5) @(posedge clk);
		#1 rstN = 1'b1;

		readReg(boardPkg::addrStatus);
		checkAllCells();

		// Idle game rejects cell writes and result commands
		writeReg(addrOf(7), 32'(boardPkg::cellMine));
		readReg(addrOf(7));
		writeReg(boardPkg::addrCmd, 32'(boardPkg::cmdWin));
		writeReg(addrOf(cellCount), 32'h1); // One past the last cell
		readReg(addrOf(cellCount));
		readReg(12'h102);

		writeReg(boardPkg::addrCmd, 32'(boardPkg::cmdStart));
		fillRandom();
		checkAllCells();
		scanFrame();

		writeReg(boardPkg::addrCmd, 32'(boardPkg::cmdWin));
		scanFrame(); // Green grid
		writeReg(addrOf(3), 32'(boardPkg::cellFlag));
		readReg(addrOf(3));

		writeReg(boardPkg::addrCmd, 32'(boardPkg::cmdIdle));
		writeReg(boardPkg::addrCmd, 32'(boardPkg::cmdStart));
		checkAllCells();
		fillRandom();
		writeReg(boardPkg::addrCmd, 32'(boardPkg::cmdLose));
		readReg(boardPkg::addrStatus);
		scanFrame(); // Red grid
		finishRun();
	end

endmodule

/* all.f */
vgaPkg.sv
boardPkg.sv
vgaTiming.sv
gameControl.sv
cellMemory.sv
boardRenderer.sv
boardDisplay.sv
tbBoardDisplay.sv

/* Bender.yml */
package:
  name: boardDisplay

sources:
  - vgaPkg.sv
  - boardPkg.sv
  - vgaTiming.sv
  - gameControl.sv
  - cellMemory.sv
  - boardRenderer.sv
  - boardDisplay.sv
  - target: test
    files:
      - tbBoardDisplay.sv
